// File: rtl/memCtrlPkg.sv
package memCtrlPkg;

    localparam int addrWidth    = 32;
    localparam int byteWidth    = 8;
    localparam int wordWidth    = 32;
    localparam int bytesPerWord = 4;

    // index of a byte inside a word
    localparam int idxWidth = $clog2(bytesPerWord);

    // bytes per data access, only 1, 2 and 4 are legal
    typedef logic [2:0] accessLen_t;

    // instruction fetches always read a full word
    localparam accessLen_t fetchLen = accessLen_t'(bytesPerWord);

    typedef enum logic [1:0] {
        ownIdle  = 2'd0,
        ownFetch = 2'd1,
        ownData  = 2'd2
    } owner_t;

    // request from the data port
    typedef struct packed {
        logic [addrWidth-1:0] addr;
        accessLen_t           len;
        logic                 isStore;
        logic [wordWidth-1:0] wdata;
    } dataReq_t;

    // one byte access on the RAM
    typedef struct packed {
        logic [addrWidth-1:0] addr;
        logic                 write;
        logic [byteWidth-1:0] wdata;
    } ramBus_t;

    // transaction handed from the arbiter to the sequencer
    typedef struct packed {
        owner_t               owner;
        logic [addrWidth-1:0] addr;
        accessLen_t           len;
        logic                 isStore;
        logic [wordWidth-1:0] wdata;
    } grant_t;

endpackage

// File: rtl/memArbiter.sv
module memArbiter (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           freeze,
    input  logic                           fetchEn,
    input  logic [memCtrlPkg::addrWidth-1:0] fetchAddr,
    input  logic                           dataEn,
    input  memCtrlPkg::dataReq_t           dataReq,
    input  logic                           finish,
    output memCtrlPkg::grant_t             grant,
    output logic                           start,
    output memCtrlPkg::owner_t             owner
);
    import memCtrlPkg::*;

    owner_t   ownerQ;
    dataReq_t reqQ;
    dataReq_t nextReq;
    owner_t   nextOwner;
    logic     startQ;
    logic     finishQ;
    logic     accept;

    assign accept = (ownerQ == ownIdle) && (dataEn || fetchEn);

    // data port wins a tie
    always_comb begin
        if (dataEn) begin
            nextOwner = ownData;
            nextReq   = dataReq;
        end else begin
            nextOwner       = ownFetch;
            nextReq.addr    = fetchAddr;
            nextReq.len     = fetchLen;
            nextReq.isStore = 1'b0;
            nextReq.wdata   = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ownerQ  <= ownIdle;
            startQ  <= 1'b0;
            finishQ <= 1'b0;
        end else if (!freeze) begin
            startQ  <= accept;
            // one cycle late so owner stays valid through the done pulse
            finishQ <= finish;
            if (accept) begin
                ownerQ <= nextOwner;
            end else if (finishQ) begin
                ownerQ <= ownIdle;
            end
        end
    end

    // request payload, only loaded on acceptance
    always_ff @(posedge clk) begin
        if (!freeze && accept) begin
            reqQ <= nextReq;
        end
    end

    assign grant.owner   = ownerQ;
    assign grant.addr    = reqQ.addr;
    assign grant.len     = reqQ.len;
    assign grant.isStore = reqQ.isStore;
    assign grant.wdata   = reqQ.wdata;

    assign start = startQ;
    assign owner = ownerQ;

endmodule

// File: rtl/byteSequencer.sv
module byteSequencer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            freeze,
    input  logic                            start,
    input  memCtrlPkg::grant_t              grant,
    output memCtrlPkg::ramBus_t             ramBus,
    output logic                            readStrobe,
    output logic [memCtrlPkg::idxWidth-1:0] readIndex,
    output logic                            finish
);
    import memCtrlPkg::*;

    logic                busy;
    logic                active;
    logic [idxWidth-1:0] count;
    logic                lastByte;
    ramBus_t             busLive;
    ramBus_t             busPrev;
    logic                rdStrobeQ;
    logic [idxWidth-1:0] rdIndexQ;
    logic                rdLastQ;
    logic                storeLast;

    // start covers the first byte, busy the rest
    assign active = start || busy;

    assign lastByte = (accessLen_t'({1'b0, count}) + accessLen_t'(1)) == grant.len;

    always_comb begin
        busLive.addr  = grant.addr + addrWidth'(count);
        busLive.write = active && grant.isStore;
        busLive.wdata = grant.wdata[count*byteWidth +: byteWidth];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (!freeze && active) begin
            if (lastByte) begin
                busy  <= 1'b0;
                count <= '0;
            end else begin
                busy  <= 1'b1;
                count <= count + 1'b1;
            end
        end
    end

    // strobe lags the address by one cycle, same as the RAM read
    always_ff @(posedge clk) begin
        if (rst) begin
            rdStrobeQ <= 1'b0;
            rdLastQ   <= 1'b0;
        end else if (!freeze) begin
            rdStrobeQ <= active && !grant.isStore;
            rdLastQ   <= active && !grant.isStore && lastByte;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            rdIndexQ <= count;
        end
    end

    // last bus seen by the RAM before a freeze
    always_ff @(posedge clk) begin
        if (!freeze) begin
            busPrev <= busLive;
        end
    end

    // while frozen the RAM keeps seeing the last unfrozen address,
    // so the byte behind a pending strobe is still there afterwards
    always_comb begin
        if (freeze) begin
            ramBus.addr  = busPrev.addr;
            ramBus.write = 1'b0;
            ramBus.wdata = busPrev.wdata;
        end else begin
            ramBus = busLive;
        end
    end

    assign storeLast = active && grant.isStore && lastByte;

    assign readStrobe = rdStrobeQ;
    assign readIndex  = rdIndexQ;
    assign finish     = storeLast || rdLastQ;

endmodule

// File: rtl/wordAssembler.sv
module wordAssembler (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             freeze,
    input  memCtrlPkg::owner_t               owner,
    input  logic                             readStrobe,
    input  logic [memCtrlPkg::idxWidth-1:0]  readIndex,
    input  logic                             finish,
    input  logic [memCtrlPkg::byteWidth-1:0] ramRdata,
    output logic                             fetchDone,
    output logic [memCtrlPkg::wordWidth-1:0] fetchInst,
    output logic                             dataDone,
    output logic [memCtrlPkg::wordWidth-1:0] loadData
);
    import memCtrlPkg::*;

    logic [wordWidth-1:0] acc;
    logic [wordWidth-1:0] merged;

    // byte 0 always comes first and clears the upper bytes
    always_comb begin
        merged = acc;
        if (readStrobe) begin
            if (readIndex == '0) begin
                merged = '0;
            end
            merged[readIndex*byteWidth +: byteWidth] = ramRdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze && readStrobe) begin
            acc <= merged;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetchDone <= 1'b0;
            dataDone  <= 1'b0;
        end else if (!freeze) begin
            fetchDone <= finish && (owner == ownFetch);
            dataDone  <= finish && (owner == ownData);
        end
    end

    // result words
    always_ff @(posedge clk) begin
        if (!freeze && finish) begin
            if (owner == ownFetch) begin
                fetchInst <= merged;
            end
            // a store has no read strobe and leaves loadData alone
            if (owner == ownData && readStrobe) begin
                loadData <= merged;
            end
        end
    end

endmodule

// File: rtl/memCtrl.sv
module memCtrl (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             rdy,
    input  logic                             ioBufferFull,
    input  logic                             fetchEn,
    input  logic [memCtrlPkg::addrWidth-1:0] fetchAddr,
    input  logic                             dataEn,
    input  memCtrlPkg::dataReq_t             dataReq,
    input  logic [memCtrlPkg::byteWidth-1:0] ramRdata,
    output memCtrlPkg::ramBus_t              ramBus,
    output memCtrlPkg::owner_t               owner,
    output logic                             fetchDone,
    output logic [memCtrlPkg::wordWidth-1:0] fetchInst,
    output logic                             dataDone,
    output logic [memCtrlPkg::wordWidth-1:0] loadData
);
    import memCtrlPkg::*;

    logic                freeze;
    grant_t              grant;
    logic                start;
    logic                finish;
    logic                readStrobe;
    logic [idxWidth-1:0] readIndex;

    // global stall
    assign freeze = ioBufferFull || !rdy;

    memArbiter i_arbiter (
        .clk       (clk),
        .rst       (rst),
        .freeze    (freeze),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .dataEn    (dataEn),
        .dataReq   (dataReq),
        .finish    (finish),
        .grant     (grant),
        .start     (start),
        .owner     (owner)
    );

    byteSequencer i_sequencer (
        .clk        (clk),
        .rst        (rst),
        .freeze     (freeze),
        .start      (start),
        .grant      (grant),
        .ramBus     (ramBus),
        .readStrobe (readStrobe),
        .readIndex  (readIndex),
        .finish     (finish)
    );

    wordAssembler i_assembler (
        .clk        (clk),
        .rst        (rst),
        .freeze     (freeze),
        .owner      (owner),
        .readStrobe (readStrobe),
        .readIndex  (readIndex),
        .finish     (finish),
        .ramRdata   (ramRdata),
        .fetchDone  (fetchDone),
        .fetchInst  (fetchInst),
        .dataDone   (dataDone),
        .loadData   (loadData)
    );

endmodule

// File: sim/tbClock.sv
module tbClock (
    output logic clk
);

    // period of 4 time units
    initial begin
        clk = 1'b0;
    end

    always begin
        #2 clk = ~clk;
    end

endmodule

// File: sim/ramModel.sv
module ramModel (
    input  logic                             clk,
    input  memCtrlPkg::ramBus_t              ramBus,
    output logic [memCtrlPkg::byteWidth-1:0] ramRdata
);
    import memCtrlPkg::*;

    // 256 bytes decoded from the low address byte
    logic [byteWidth-1:0] mem [0:255];

    always @(posedge clk) begin
        if (ramBus.write) begin
            mem[ramBus.addr[7:0]] <= ramBus.wdata;
        end
        // registered read one cycle behind the address
        ramRdata <= mem[ramBus.addr[7:0]];
    end

endmodule

// File: sim/memCtrlTb.sv
module memCtrlTb;
    import memCtrlPkg::*;

    localparam int resetCycles    = 8;
    localparam int cyclesPerTrans = 20;
    localparam int numRandom      = 40;
    localparam logic [31:0] seed  = 32'hcf87_707e;

    logic                 clk;
    logic                 rst;
    logic                 rdy;
    logic                 ioBufferFull;
    logic                 fetchEn;
    logic [addrWidth-1:0] fetchAddr;
    logic                 dataEn;
    dataReq_t             dataReq;
    logic [byteWidth-1:0] ramRdata;
    ramBus_t              ramBus;
    owner_t               owner;
    logic                 fetchDone;
    logic [wordWidth-1:0] fetchInst;
    logic                 dataDone;
    logic [wordWidth-1:0] loadData;

    logic [7:0]  shadow [0:255];
    logic [31:0] rngState;
    logic [31:0] stallRng;
    logic        stallOn;
    int          cyc;
    int          transCount;
    int          frozenCount;
    int          fetchReqCyc;
    int          dataReqCyc;
    int          storeIdx;
    int          lastFetchDone;
    int          lastDataDone;
    logic        rstPrev;
    logic        expectAccept;
    owner_t      expectOwner;
    owner_t      prevOwner;
    ramBus_t     lastBus;
    logic [31:0] expFetchAddr;
    dataReq_t    expData;

    tbClock i_clock (.clk(clk));

    ramModel i_ram (
        .clk      (clk),
        .ramBus   (ramBus),
        .ramRdata (ramRdata)
    );

    memCtrl i_dut (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetchEn      (fetchEn),
        .fetchAddr    (fetchAddr),
        .dataEn       (dataEn),
        .dataReq      (dataReq),
        .ramRdata     (ramRdata),
        .ramBus       (ramBus),
        .owner        (owner),
        .fetchDone    (fetchDone),
        .fetchInst    (fetchInst),
        .dataDone     (dataDone),
        .loadData     (loadData)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    // little-endian word from the shadow RAM with zeros above len bytes
    function automatic logic [31:0] shadowWord(input logic [31:0] addr, input int len);
        logic [31:0] w;
        logic [7:0]  idx;
        w = '0;
        for (int k = 0; k < len; k++) begin
            idx = addr[7:0] + 8'(k);
            w[8*k +: 8] = shadow[idx];
        end
        return w;
    endfunction

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    // checks run on the rising edge while inputs change on the falling edge
    always @(posedge clk) begin : monitor
        logic frozen;
        frozen = ioBufferFull || !rdy;
        if (cyc > 0 && (rst || rstPrev)) begin
            assert (owner == ownIdle && !fetchDone && !dataDone && !ramBus.write)
            else stopOnError($sformatf("FAILED reset: owner %h fetchDone %h dataDone %h write %h",
                owner, fetchDone, dataDone, ramBus.write));
        end
        if (frozen) begin
            frozenCount++;
            assert (!ramBus.write)
            else stopOnError($sformatf("FAILED ramBus.write: got %h expected 0", ramBus.write));
            assert (ramBus.addr == lastBus.addr && ramBus.wdata == lastBus.wdata)
            else stopOnError($sformatf("FAILED ramBus: got %h expected %h", ramBus, lastBus));
        end else begin
            lastBus = ramBus;
        end
        if (!rst) begin
            if (expectAccept) begin
                assert (owner == expectOwner)
                else stopOnError($sformatf("FAILED owner: got %h expected %h", owner, expectOwner));
                expectAccept = 1'b0;
            end
            if (prevOwner != ownIdle && owner != ownIdle) begin
                assert (owner == prevOwner)
                else stopOnError($sformatf("FAILED owner: got %h expected %h", owner, prevOwner));
            end
            if (!frozen && owner == ownIdle && (dataEn || fetchEn)) begin
                expectAccept = 1'b1;
                if (dataEn) begin
                    expectOwner = ownData;
                    dataReqCyc  = cyc;
                    storeIdx    = 0;
                end else begin
                    expectOwner = ownFetch;
                    fetchReqCyc = cyc;
                end
            end
            if (ramBus.write) begin
                assert (storeIdx < int'(expData.len) && ramBus.addr == expData.addr + storeIdx
                        && ramBus.wdata == expData.wdata[8*storeIdx +: 8])
                else stopOnError($sformatf("FAILED ramBus: got addr %h byte %h expected %h %h",
                    ramBus.addr, ramBus.wdata, expData.addr + storeIdx,
                    expData.wdata[8*storeIdx +: 8]));
                shadow[8'(expData.addr + storeIdx)] = expData.wdata[8*storeIdx +: 8];
                storeIdx++;
            end
            if (fetchDone) begin
                assert (fetchInst == shadowWord(expFetchAddr, 4))
                else stopOnError($sformatf("FAILED fetchInst: got %h expected %h",
                    fetchInst, shadowWord(expFetchAddr, 4)));
                if (!stallOn) begin
                    assert (cyc - fetchReqCyc == 6)
                    else stopOnError($sformatf("FAILED fetchDone latency: got %h expected %h",
                        cyc - fetchReqCyc, 6));
                end
                lastFetchDone = cyc;
            end
            if (dataDone) begin
                if (expData.isStore) begin
                    assert (storeIdx == int'(expData.len))
                    else stopOnError("store finished before all bytes were written");
                end else begin
                    assert (loadData == shadowWord(expData.addr, int'(expData.len)))
                    else stopOnError($sformatf("FAILED loadData: got %h expected %h",
                        loadData, shadowWord(expData.addr, int'(expData.len))));
                end
                if (!stallOn) begin
                    assert (cyc - dataReqCyc == int'(expData.len) + (expData.isStore ? 1 : 2))
                    else stopOnError($sformatf("FAILED dataDone latency: got %h expected %h",
                        cyc - dataReqCyc, int'(expData.len) + (expData.isStore ? 1 : 2)));
                end
                lastDataDone = cyc;
            end
        end
        rstPrev   = rst;
        prevOwner = owner;
        cyc++;
    end

    // budget grows with every transaction and every frozen cycle
    always @(posedge clk) begin
        if (cyc > resetCycles + cyclesPerTrans * (transCount + 1) + frozenCount) begin
            stopOnError("timeout, a transaction never finished");
        end
    end

    // random freeze cycles
    always @(negedge clk) begin
        if (stallOn && !rst) begin
            stallRng     = xorshift(stallRng);
            ioBufferFull = (stallRng[1:0] == 2'd0);
            rdy          = (stallRng[3:2] != 2'd0);
        end else begin
            ioBufferFull = 1'b0;
            rdy          = 1'b1;
        end
    end

    task automatic runFetch(input logic [31:0] addr);
        @(negedge clk);
        expFetchAddr = addr;
        fetchAddr    = addr;
        fetchEn      = 1'b1;
        transCount++;
        do @(negedge clk); while (!fetchDone);
        fetchEn = 1'b0;
        // done stays high through frozen cycles
        while (fetchDone) @(negedge clk);
    endtask

    task automatic runData(input logic [31:0] addr, input int len, input logic isStore,
                           input logic [31:0] wdata);
        @(negedge clk);
        dataReq.addr    = addr;
        dataReq.len     = accessLen_t'(len);
        dataReq.isStore = isStore;
        dataReq.wdata   = wdata;
        expData         = dataReq;
        dataEn          = 1'b1;
        transCount++;
        do @(negedge clk); while (!dataDone);
        dataEn = 1'b0;
        while (dataDone) @(negedge clk);
    endtask

    // both ports ask in the same cycle and data has to finish first
    task automatic runBoth(input logic [31:0] fAddr, input logic [31:0] dAddr);
        logic gotFetch;
        logic gotData;
        gotFetch = 1'b0;
        gotData  = 1'b0;
        @(negedge clk);
        expFetchAddr    = fAddr;
        fetchAddr       = fAddr;
        dataReq.addr    = dAddr;
        dataReq.len     = accessLen_t'(4);
        dataReq.isStore = 1'b0;
        dataReq.wdata   = '0;
        expData         = dataReq;
        fetchEn         = 1'b1;
        dataEn          = 1'b1;
        transCount      = transCount + 2;
        while (!(gotFetch && gotData)) begin
            @(negedge clk);
            if (dataDone) begin
                dataEn  = 1'b0;
                gotData = 1'b1;
            end
            if (fetchDone) begin
                fetchEn  = 1'b0;
                gotFetch = 1'b1;
            end
        end
        while (fetchDone) @(negedge clk);
        assert (lastDataDone < lastFetchDone)
        else stopOnError("fetch finished before the data request that won arbitration");
    endtask

    task automatic runRandom();
        logic [31:0] r;
        logic [31:0] addr;
        int          len;
        r    = nextRand();
        addr = nextRand() % 252;
        len  = (r[3:2] == 2'd0) ? 1 : (r[3:2] == 2'd1) ? 2 : 4;
        case (r[1:0])
            2'd0: runFetch(addr);
            2'd1: runData(addr, len, 1'b0, '0);
            default: begin
                runData(addr, len, 1'b1, nextRand());
                runData(addr, len, 1'b0, '0);
            end
        endcase
    endtask

    initial begin
        rst          = 1'b1;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        fetchEn      = 1'b0;
        fetchAddr    = '0;
        dataEn       = 1'b0;
        dataReq      = '0;
        stallOn      = 1'b0;
        rngState     = seed;
        stallRng     = seed;
        cyc          = 0;
        transCount   = 0;
        frozenCount  = 0;
        storeIdx     = 0;
        rstPrev      = 1'b1;
        expectAccept = 1'b0;
        prevOwner    = ownIdle;
        expData      = '0;
        expFetchAddr = '0;
        for (int i = 0; i < 256; i++) begin
            i_ram.mem[i[7:0]] = 8'(i * 37 + 17);
            shadow[i[7:0]]    = 8'(i * 37 + 17);
        end
        repeat (resetCycles) @(negedge clk);
        rst = 1'b0;

        runFetch(32'd16);
        runData(32'd33, 1, 1'b0, '0);
        runData(32'd34, 2, 1'b0, '0);
        runData(32'd40, 4, 1'b0, '0);
        runData(32'd64, 4, 1'b1, 32'hdead_beef);
        runData(32'd64, 4, 1'b0, '0);
        runData(32'd81, 1, 1'b1, 32'h0000_00a5);
        runData(32'd90, 2, 1'b1, 32'h0000_c33c);
        runData(32'd90, 4, 1'b0, '0);
        runBoth(32'd100, 32'd120);

        stallOn = 1'b1;
        repeat (numRandom) runRandom();
        runBoth(32'd200, 32'd64);
        stallOn = 1'b0;

        repeat (4) @(negedge clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: flist.f
rtl/memCtrlPkg.sv
rtl/memArbiter.sv
rtl/byteSequencer.sv
rtl/wordAssembler.sv
rtl/memCtrl.sv
sim/tbClock.sv
sim/ramModel.sv
sim/memCtrlTb.sv

// File: run.sh
#!/bin/sh
# build and run the memCtrl testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f flist.f \
    --top-module memCtrlTb \
    -o memCtrlSim

./obj_dir/memCtrlSim
